// ==== hdl/SchedulerPkg.sv ====
`default_nettype none

package SchedulerPkg;

    // Issue queue geometry.
    localparam int ENTRY_NUM      = 8;
    localparam int DISPATCH_WIDTH = 2;

    // Physical register tag width.
    localparam int REG_TAG_WIDTH  = 5;

    // Bits needed to name one queue entry.
    localparam int INDEX_WIDTH    = 3;

    // Wide enough to count from zero up to a full queue.
    localparam int COUNT_WIDTH    = $clog2(ENTRY_NUM + 1);

    // Names one issue queue entry.
    typedef logic [INDEX_WIDTH-1:0] IqIndex;

    // Physical register tag; zero is the cleared value.
    typedef logic [REG_TAG_WIDTH-1:0] RegTag;

    // One bit per entry, used for free, valid and request vectors.
    typedef logic [ENTRY_NUM-1:0] EntryMask;

    // Number of entries, for free counts and lane counts.
    typedef logic [COUNT_WIDTH-1:0] EntryCount;

    // Destination table clear sweep after reset.
    typedef enum logic {
        SWEEP_IDLE,
        SWEEP_RUN
    } SweepState;

endpackage

`default_nettype wire

// ==== hdl/WakeupSelectIf.sv ====
`default_nettype none

interface WakeupSelectIf import SchedulerPkg::*; ();

    // Dispatch write lanes.
    logic   write[DISPATCH_WIDTH];
    IqIndex writePtr[DISPATCH_WIDTH];
    RegTag  writeDstTag[DISPATCH_WIDTH];

    // Selected entry and its broadcast tag.
    IqIndex wakeupPtr;
    logic   wakeupValid;
    RegTag  wakeupDstTag;

    // High while the destination table is being cleared.
    logic   initBusy;

    modport FreeList (
        output write,
        output writePtr,
        input  wakeupValid,
        input  wakeupPtr,
        input  initBusy
    );

    modport DestinationRam (
        input  write,
        input  writePtr,
        input  writeDstTag,
        input  wakeupPtr,
        output wakeupDstTag,
        output initBusy
    );

    // The matrix also needs the pointer to retire the issued entry.
    modport Matrix (
        input  write,
        input  writePtr,
        input  wakeupValid,
        input  wakeupPtr,
        input  wakeupDstTag
    );

    modport Selector (
        output wakeupPtr,
        output wakeupValid
    );

endinterface

`default_nettype wire

// ==== hdl/DestinationRam.sv ====
`default_nettype none

module DestinationRam import SchedulerPkg::*; (
    input logic clk,
    input logic rstN,
    WakeupSelectIf.DestinationRam port
);

    // Destination tag of each queue entry.
    RegTag tagTable[ENTRY_NUM];

    SweepState sweepState;
    IqIndex    sweepIndex;

    // Write lanes after the sweep has been merged in.
    logic   write[DISPATCH_WIDTH];
    IqIndex writePtr[DISPATCH_WIDTH];
    RegTag  writeData[DISPATCH_WIDTH];

    // Clear sweep walks every entry once after reset.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweepState <= SWEEP_RUN;
            sweepIndex <= '0;
        end else if (sweepState == SWEEP_RUN) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == IqIndex'(ENTRY_NUM - 1)) begin
                sweepState <= SWEEP_IDLE;
            end
        end
    end

    always_comb begin
        port.initBusy = (sweepState == SWEEP_RUN);
    end

    // Sweep takes write port 0 and silences the other lanes.
    always_comb begin
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            write[lane]     = port.write[lane];
            writePtr[lane]  = port.writePtr[lane];
            writeData[lane] = port.writeDstTag[lane];
        end
        if (sweepState == SWEEP_RUN) begin
            for (int lane = 1; lane < DISPATCH_WIDTH; lane++) begin
                write[lane] = 1'b0;
            end
            write[0]     = 1'b1;
            writePtr[0]  = sweepIndex;
            writeData[0] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            if (write[lane]) begin
                tagTable[writePtr[lane]] <= writeData[lane];
            end
        end
    end

    // Asynchronous read, so the tag leaves with the issue pulse.
    always_comb begin
        port.wakeupDstTag = tagTable[port.wakeupPtr];
    end

endmodule

`default_nettype wire

// ==== hdl/IssueQueueFreeList.sv ====
`default_nettype none

module IssueQueueFreeList import SchedulerPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic dispatchValid[DISPATCH_WIDTH],
    output logic dispatchStall,
    WakeupSelectIf.FreeList port
);

    // One bit per entry, set when the entry can take a new op.
    EntryMask  freeMask;
    EntryMask  freeNext;
    EntryMask  remaining;
    EntryCount freeCount;
    EntryCount validCount;
    IqIndex    allocPtr[DISPATCH_WIDTH];

    // Lowest free entries handed out to the valid lanes in lane order.
    always_comb begin
        remaining = freeMask;
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            allocPtr[lane] = '0;
            for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    allocPtr[lane] = IqIndex'(i);
                end
            end
            if (dispatchValid[lane]) begin
                remaining[allocPtr[lane]] = 1'b0;
            end
        end
    end

    always_comb begin
        freeCount  = '0;
        validCount = '0;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            freeCount = freeCount + EntryCount'(freeMask[i]);
        end
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            validCount = validCount + EntryCount'(dispatchValid[lane]);
        end
        dispatchStall = port.initBusy || (freeCount < validCount);
    end

    always_comb begin
        freeNext = freeMask;
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            port.write[lane]    = dispatchValid[lane] && !dispatchStall;
            port.writePtr[lane] = allocPtr[lane];
            if (port.write[lane]) begin
                freeNext[allocPtr[lane]] = 1'b0;
            end
        end
        // The issued entry is never among the ones just allocated.
        if (port.wakeupValid) begin
            freeNext[port.wakeupPtr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            freeMask <= '1;
        end else begin
            freeMask <= freeNext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/SourceTagMatrix.sv ====
`default_nettype none

module SourceTagMatrix import SchedulerPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  RegTag    srcTagA[DISPATCH_WIDTH],
    input  RegTag    srcTagB[DISPATCH_WIDTH],
    input  logic     srcReadyA[DISPATCH_WIDTH],
    input  logic     srcReadyB[DISPATCH_WIDTH],
    output EntryMask requests,
    WakeupSelectIf.Matrix port
);

    // Control state per entry.
    EntryMask valid;
    EntryMask readyA;
    EntryMask readyB;

    // Source tags per entry.
    RegTag tagA[ENTRY_NUM];
    RegTag tagB[ENTRY_NUM];

    EntryMask validNext;
    EntryMask readyANext;
    EntryMask readyBNext;
    RegTag    tagANext[ENTRY_NUM];
    RegTag    tagBNext[ENTRY_NUM];

    always_comb begin
        validNext  = valid;
        readyANext = readyA;
        readyBNext = readyB;
        tagANext   = tagA;
        tagBNext   = tagB;

        // Issued entry leaves the queue.
        if (port.wakeupValid) begin
            validNext[port.wakeupPtr] = 1'b0;
        end

        // New ops from the dispatch lanes.
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            if (port.write[lane]) begin
                validNext[port.writePtr[lane]]  = 1'b1;
                tagANext[port.writePtr[lane]]   = srcTagA[lane];
                tagBNext[port.writePtr[lane]]   = srcTagB[lane];
                readyANext[port.writePtr[lane]] = srcReadyA[lane];
                readyBNext[port.writePtr[lane]] = srcReadyB[lane];
            end
        end

        // Broadcast compare also covers ops written this cycle.
        if (port.wakeupValid) begin
            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (validNext[i] && tagANext[i] == port.wakeupDstTag) begin
                    readyANext[i] = 1'b1;
                end
                if (validNext[i] && tagBNext[i] == port.wakeupDstTag) begin
                    readyBNext[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid  <= '0;
            readyA <= '0;
            readyB <= '0;
        end else begin
            valid  <= validNext;
            readyA <= readyANext;
            readyB <= readyBNext;
        end
    end

    always_ff @(posedge clk) begin
        tagA <= tagANext;
        tagB <= tagBNext;
    end

    always_comb begin
        requests = valid & readyA & readyB;
    end

endmodule

`default_nettype wire

// ==== hdl/IssueSelector.sv ====
`default_nettype none

module IssueSelector import SchedulerPkg::*; (
    input EntryMask requests,
    WakeupSelectIf.Selector port
);

    // Index of the lowest set bit, zero when none is set.
    function automatic IqIndex lowestSet(input EntryMask mask);
        IqIndex index;
        index = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (mask[i]) begin
                index = IqIndex'(i);
            end
        end
        return index;
    endfunction

    // Oldest-first is not tracked; lowest index wins.
    always_comb begin
        port.wakeupValid = |requests;
        port.wakeupPtr   = lowestSet(requests);
    end

endmodule

`default_nettype wire

// ==== hdl/SchedulerTop.sv ====
`default_nettype none

module SchedulerTop import SchedulerPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   dispatchValid[DISPATCH_WIDTH],
    input  RegTag  dispatchDstTag[DISPATCH_WIDTH],
    input  RegTag  srcTagA[DISPATCH_WIDTH],
    input  RegTag  srcTagB[DISPATCH_WIDTH],
    input  logic   srcReadyA[DISPATCH_WIDTH],
    input  logic   srcReadyB[DISPATCH_WIDTH],
    output logic   dispatchStall,
    output logic   initBusy,
    output logic   issueValid,
    output IqIndex issueEntry,
    output RegTag  issueDstTag
);

    EntryMask requests;

    WakeupSelectIf wakeupSelect();

    // Destination tags go straight into the table lanes.
    always_comb begin
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            wakeupSelect.writeDstTag[lane] = dispatchDstTag[lane];
        end
    end

    DestinationRam destinationRam (
        .clk  (clk),
        .rstN (rstN),
        .port (wakeupSelect)
    );

    IssueQueueFreeList freeList (
        .clk           (clk),
        .rstN          (rstN),
        .dispatchValid (dispatchValid),
        .dispatchStall (dispatchStall),
        .port          (wakeupSelect)
    );

    SourceTagMatrix matrix (
        .clk       (clk),
        .rstN      (rstN),
        .srcTagA   (srcTagA),
        .srcTagB   (srcTagB),
        .srcReadyA (srcReadyA),
        .srcReadyB (srcReadyB),
        .requests  (requests),
        .port      (wakeupSelect)
    );

    IssueSelector selector (
        .requests (requests),
        .port     (wakeupSelect)
    );

    // Issue outputs.
    always_comb begin
        initBusy    = wakeupSelect.initBusy;
        issueValid  = wakeupSelect.wakeupValid;
        issueEntry  = wakeupSelect.wakeupPtr;
        issueDstTag = wakeupSelect.wakeupDstTag;
    end

endmodule

`default_nettype wire

// ==== bench/TbClock.sv ====
`default_nettype none

module TbClock (
    output logic clk
);

    // Period of 4, high and low for 2 each.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== bench/SchedulerTb.sv ====
`default_nettype none

module SchedulerTb import SchedulerPkg::*; ();

    localparam int STALL_LIMIT = 40;
    localparam int DRAIN_LIMIT = 60;

    logic   clk;
    logic   rstN;
    logic   dispatchValid[DISPATCH_WIDTH];
    RegTag  dispatchDstTag[DISPATCH_WIDTH];
    RegTag  srcTagA[DISPATCH_WIDTH];
    RegTag  srcTagB[DISPATCH_WIDTH];
    logic   srcReadyA[DISPATCH_WIDTH];
    logic   srcReadyB[DISPATCH_WIDTH];
    logic   dispatchStall;
    logic   initBusy;
    logic   issueValid;
    IqIndex issueEntry;
    RegTag  issueDstTag;

    int    checkCount;
    int    errorCount;
    int    testCount;
    RegTag issued[$];
    RegTag expected[$];
    RegTag producers[$];
    RegTag consumers[$];

    // Expected queue occupancy and the entry each dispatched tag landed in.
    bit     entryFree[ENTRY_NUM];
    IqIndex tagEntry[2**REG_TAG_WIDTH];

    TbClock clockGen (
        .clk (clk)
    );

    SchedulerTop uut (
        .clk            (clk),
        .rstN           (rstN),
        .dispatchValid  (dispatchValid),
        .dispatchDstTag (dispatchDstTag),
        .srcTagA        (srcTagA),
        .srcTagB        (srcTagB),
        .srcReadyA      (srcReadyA),
        .srcReadyB      (srcReadyB),
        .dispatchStall  (dispatchStall),
        .initBusy       (initBusy),
        .issueValid     (issueValid),
        .issueEntry     (issueEntry),
        .issueDstTag    (issueDstTag)
    );

    // Issued tags in the order they leave the queue.
    always @(posedge clk) begin
        if (rstN && issueValid) begin
            issued.push_back(issueDstTag);
            checkValue("issueEntry", issueEntry, tagEntry[issueDstTag]);
            entryFree[tagEntry[issueDstTag]] = 1'b1;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actualValue,
                              input logic [31:0] expectedValue);
        checkCount++;
        if (actualValue !== expectedValue) begin
            errorCount++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actualValue, expectedValue);
        end
    endtask

    // Lowest free entry goes to the next accepted op.
    task automatic allocateEntry(input RegTag tag);
        int found;
        found = -1;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (entryFree[i] && found < 0) begin
                found = i;
            end
        end
        if (found < 0) begin
            errorCount++;
            $display("Op with tag 0x%0h was accepted while no entry was free", tag);
        end else begin
            entryFree[found] = 1'b0;
            tagEntry[tag] = IqIndex'(found);
        end
    endtask

    task automatic idleLanes();
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            dispatchValid[lane]  = 1'b0;
            dispatchDstTag[lane] = '0;
            srcTagA[lane]        = '0;
            srcTagB[lane]        = '0;
            srcReadyA[lane]      = 1'b0;
            srcReadyB[lane]      = 1'b0;
        end
    endtask

    task automatic resetAndSweep();
        int cycles;
        cycles = 0;
        rstN = 1'b0;
        repeat (5) begin
            @(negedge clk);
            checkValue("initBusy", initBusy, 1);
            checkValue("dispatchStall", dispatchStall, 1);
            checkValue("issueValid", issueValid, 0);
        end
        rstN = 1'b1;
        // Sweep clears one entry per cycle.
        while (initBusy && cycles <= ENTRY_NUM + 2) begin
            checkValue("dispatchStall", dispatchStall, 1);
            checkValue("issueValid", issueValid, 0);
            @(negedge clk);
            cycles++;
        end
        if (initBusy) begin
            errorCount++;
            $display("Destination table sweep still busy after %0d cycles", cycles);
        end
        checkValue("initBusyCycles", cycles, ENTRY_NUM);
    endtask

    // Drives one cycle of lanes and holds them while the queue stalls.
    task automatic dispatchOps(input int fd, inout bit stallSeen);
        int code;
        int valid;
        int dstTag;
        int tagA;
        int tagB;
        int readyA;
        int readyB;
        int waited;
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            code = $fscanf(fd, "%h %h %h %h %h %h", valid, dstTag, tagA, tagB, readyA, readyB);
            dispatchValid[lane]  = (valid != 0);
            dispatchDstTag[lane] = RegTag'(dstTag);
            srcTagA[lane]        = RegTag'(tagA);
            srcTagB[lane]        = RegTag'(tagB);
            srcReadyA[lane]      = (readyA != 0);
            srcReadyB[lane]      = (readyB != 0);
        end
        waited = 0;
        #1;
        while (dispatchStall && waited < STALL_LIMIT) begin
            stallSeen = 1'b1;
            @(negedge clk);
            #1;
            waited++;
        end
        if (dispatchStall) begin
            errorCount++;
            $display("Dispatch stayed stalled for %0d cycles", waited);
        end else begin
            // Accepted at the coming rising edge, lane 0 first.
            for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
                if (dispatchValid[lane]) begin
                    allocateEntry(dispatchDstTag[lane]);
                end
            end
        end
        for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
            if (dispatchValid[lane] && !srcReadyA[lane]) begin
                producers.push_back(srcTagA[lane]);
                consumers.push_back(dispatchDstTag[lane]);
            end
            if (dispatchValid[lane] && !srcReadyB[lane]) begin
                producers.push_back(srcTagB[lane]);
                consumers.push_back(dispatchDstTag[lane]);
            end
        end
        @(negedge clk);
    endtask

    function automatic int issuePosition(input RegTag tag);
        int position;
        position = -1;
        foreach (issued[i]) begin
            if (issued[i] == tag && position < 0) begin
                position = i;
            end
        end
        return position;
    endfunction

    task automatic finishTest(input int testId, input bit stallExpected, input bit stallSeen,
                              input int errorsBefore);
        int waited;
        int producerPos;
        int consumerPos;
        idleLanes();
        waited = 0;
        while (issued.size() < expected.size() && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (issued.size() < expected.size()) begin
            errorCount++;
            $display("Test %0d timed out with %0d of %0d ops issued", testId,
                     issued.size(), expected.size());
        end
        checkValue("issueCount", issued.size(), expected.size());
        // Queue is empty once every op has left.
        checkValue("issueValid", issueValid, 0);
        foreach (expected[i]) begin
            if (i < issued.size()) begin
                checkValue("issueDstTag", issued[i], expected[i]);
            end
        end
        checkValue("dispatchStall", stallSeen, stallExpected);
        // A consumer must leave strictly after its producer.
        foreach (consumers[i]) begin
            producerPos = issuePosition(producers[i]);
            consumerPos = issuePosition(consumers[i]);
            if (consumerPos >= 0) begin
                checkValue("dependencyOrder", producerPos >= 0 && producerPos < consumerPos, 1);
            end
        end
        $display("Test %0d: %0d ops, %s", testId, expected.size(),
                 (errorCount == errorsBefore) ? "ok" : "errors");
        testCount++;
    endtask

    initial begin
        int    fd;
        int    code;
        int    testId;
        int    stallExpected;
        int    errorsBefore;
        int    tagCount;
        int    tagValue;
        bit    stallSeen;
        string kind;
        string comment;
        checkCount = 0;
        errorCount = 0;
        testCount  = 0;
        testId = 0;
        stallExpected = 0;
        stallSeen = 1'b0;
        foreach (entryFree[i]) begin
            entryFree[i] = 1'b1;
        end
        rstN = 1'b0;
        idleLanes();
        void'($urandom(73));

        errorsBefore = errorCount;
        resetAndSweep();
        $display("Test reset: %s", (errorCount == errorsBefore) ? "ok" : "errors");
        testCount++;

        fd = $fopen("bench/schedulerInput.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open bench/schedulerInput.txt");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(comment, fd);
                end else if (kind == "test") begin
                    code = $fscanf(fd, "%d %d", testId, stallExpected);
                    issued.delete();
                    expected.delete();
                    producers.delete();
                    consumers.delete();
                    stallSeen = 1'b0;
                    errorsBefore = errorCount;
                    repeat ($urandom_range(3, 0)) @(negedge clk);
                    @(negedge clk);
                end else if (kind == "op") begin
                    dispatchOps(fd, stallSeen);
                end else if (kind == "exp") begin
                    code = $fscanf(fd, "%d", tagCount);
                    repeat (tagCount) begin
                        code = $fscanf(fd, "%h", tagValue);
                        expected.push_back(RegTag'(tagValue));
                    end
                end else if (kind == "end") begin
                    finishTest(testId, stallExpected != 0, stallSeen, errorsBefore);
                end else begin
                    errorCount++;
                    $display("Unknown record %s in the input file", kind);
                end
            end
            $fclose(fd);
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/schedulerInput.txt ====
# Records: test <id> <stall expected>, op <lane 0> <lane 1>, exp <count> <tags>, end.
# Lane fields: valid dstTag srcTagA srcTagB readyA readyB; tags in hex.

# Independent ops issue in lowest free entry order.
test 1 0
op 1 01 00 00 1 1 1 02 00 00 1 1
op 1 03 00 00 1 1 1 04 00 00 1 1
op 1 05 00 00 1 1 1 06 00 00 1 1
exp 6 01 02 05 03 04 06
end

# Dependents, one dispatched while its producer issues.
test 2 0
op 1 0a 00 00 1 1 1 0b 0a 00 0 1
op 1 0c 0b 0a 0 0 1 0d 00 00 1 1
exp 4 0a 0b 0c 0d
end

# Full queue, the ninth op waits for a free entry.
test 3 1
op 1 10 1e 00 0 1 1 11 1e 00 0 1
op 1 12 1e 00 0 1 1 13 1e 00 0 1
op 1 14 1e 00 0 1 1 15 1e 00 0 1
op 1 1e 00 00 1 1 1 16 1e 00 0 1
op 1 17 00 00 1 1 0 00 00 00 0 0
exp 9 1e 10 11 12 13 14 15 17 16
end

# Chain of dependent ops.
test 4 0
op 1 18 00 00 1 1 1 19 18 00 0 1
op 1 1a 00 19 1 0 1 1b 1a 00 0 1
op 1 1c 1b 00 0 1 0 00 00 00 0 0
exp 5 18 19 1a 1b 1c
end

// ==== flist.f ====
hdl/SchedulerPkg.sv
hdl/WakeupSelectIf.sv
hdl/DestinationRam.sv
hdl/IssueQueueFreeList.sv
hdl/SourceTagMatrix.sv
hdl/IssueSelector.sv
hdl/SchedulerTop.sv
bench/TbClock.sv
bench/SchedulerTb.sv

// ==== Bender.yml ====
package:
  name: scheduler

sources:
  - files:
      - hdl/SchedulerPkg.sv
      - hdl/WakeupSelectIf.sv
      - hdl/DestinationRam.sv
      - hdl/IssueQueueFreeList.sv
      - hdl/SourceTagMatrix.sv
      - hdl/IssueSelector.sv
      - hdl/SchedulerTop.sv
  - target: test
    files:
      - bench/TbClock.sv
      - bench/SchedulerTb.sv
